// ==== logic/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Data path and address width
`define EXEC_XLEN 32

// Register file address width
`define EXEC_REG_AW 5

// Multiplier stage count
`define EXEC_RVM_DEPTH 5

// Local data memory
`define EXEC_DMEM_WORDS 64
`define EXEC_DMEM_AW 6

`endif

// ==== logic/exec_pkg.sv ====
package exec_pkg;

    // Target pipeline of an issued operation
    typedef enum logic [1:0] {
        PIPE_NONE = 2'd0,
        PIPE_EX   = 2'd1,
        PIPE_MEM  = 2'd2,
        PIPE_RVM  = 2'd3
    } pipe_sel_e;

    // ALU, branch and multiply operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHU
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_LW  = 2'd0,
        MEM_LB  = 2'd1,
        MEM_LBU = 2'd2,
        MEM_SW  = 2'd3
    } mem_op_e;

    // Operand source for bypassing
    typedef enum logic [1:0] {
        BYP_NONE = 2'd0,
        BYP_EX   = 2'd1,
        BYP_MEM  = 2'd2,
        BYP_RVM  = 2'd3
    } bypass_sel_e;

endpackage : exec_pkg

// ==== logic/ex_stage.sv ====
`include "exec_defs.svh"

module ex_stage (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    input  exec_pkg::alu_op_e       op_i,
    input  logic [`EXEC_XLEN-1:0]   src_a_i,
    input  logic [`EXEC_XLEN-1:0]   src_b_i,
    input  logic [`EXEC_XLEN-1:0]   pc_i,
    input  logic [`EXEC_XLEN-1:0]   br_offset_i,
    input  logic                    we_i,
    input  logic [`EXEC_REG_AW-1:0] waddr_i,
    output logic                    we_o,
    output logic [`EXEC_REG_AW-1:0] waddr_o,
    output logic [`EXEC_XLEN-1:0]   data_o,
    output logic                    branch_done_o,
    output logic                    br_taken_o,
    output logic [`EXEC_XLEN-1:0]   new_pc_o
);

    logic [`EXEC_XLEN-1:0]   alu_res;
    logic [`EXEC_XLEN-1:0]   target;
    logic [4:0]              shamt;
    logic                    is_branch;
    logic                    cond;
    logic                    lt_signed;

    logic                    we_q;
    logic                    branch_q;
    logic                    taken_q;
    logic [`EXEC_REG_AW-1:0] waddr_q;
    logic [`EXEC_XLEN-1:0]   res_q;
    logic [`EXEC_XLEN-1:0]   pc_q;

    assign shamt     = src_b_i[4:0];
    assign lt_signed = $signed(src_a_i) < $signed(src_b_i);

    always_comb begin
        alu_res   = '0;
        is_branch = 1'b0;
        cond      = 1'b0;
        case (op_i)
            exec_pkg::ALU_ADD: alu_res = src_a_i + src_b_i;
            exec_pkg::ALU_SUB: alu_res = src_a_i - src_b_i;
            exec_pkg::ALU_AND: alu_res = src_a_i & src_b_i;
            exec_pkg::ALU_OR:  alu_res = src_a_i | src_b_i;
            exec_pkg::ALU_XOR: alu_res = src_a_i ^ src_b_i;
            exec_pkg::ALU_SLL: alu_res = src_a_i << shamt;
            exec_pkg::ALU_SRL: alu_res = src_a_i >> shamt;
            exec_pkg::ALU_SLT: alu_res = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
            exec_pkg::ALU_BEQ: begin
                is_branch = 1'b1;
                cond      = (src_a_i == src_b_i);
            end
            exec_pkg::ALU_BNE: begin
                is_branch = 1'b1;
                cond      = (src_a_i != src_b_i);
            end
            exec_pkg::ALU_BLT: begin
                is_branch = 1'b1;
                cond      = lt_signed;
            end
            default: alu_res = '0;
        endcase
    end

    // Fall through to the next instruction when not taken
    assign target = cond ? pc_i + br_offset_i : pc_i + `EXEC_XLEN'(4);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            we_q     <= 1'b0;
            branch_q <= 1'b0;
            taken_q  <= 1'b0;
        end else begin
            we_q     <= valid_i & we_i & ~is_branch;
            branch_q <= valid_i & is_branch;
            taken_q  <= valid_i & is_branch & cond;
        end
    end

    always_ff @(posedge clk_i) begin
        waddr_q <= waddr_i;
        res_q   <= alu_res;
        pc_q    <= target;
    end

    assign we_o          = we_q;
    assign waddr_o       = waddr_q;
    assign data_o        = we_q ? res_q : '0;
    assign branch_done_o = branch_q;
    assign br_taken_o    = taken_q;
    assign new_pc_o      = pc_q;

endmodule : ex_stage

// ==== logic/mem_pipeline.sv ====
`include "exec_defs.svh"

module mem_pipeline (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    input  exec_pkg::mem_op_e       op_i,
    input  logic [`EXEC_XLEN-1:0]   base_i,
    input  logic [`EXEC_XLEN-1:0]   offset_i,
    input  logic [`EXEC_XLEN-1:0]   st_data_i,
    input  logic                    we_i,
    input  logic [`EXEC_REG_AW-1:0] waddr_i,
    output logic                    we_o,
    output logic [`EXEC_REG_AW-1:0] waddr_o,
    output logic [`EXEC_XLEN-1:0]   data_o,
    output logic                    st_done_o,
    output logic [`EXEC_REG_AW-1:0] addr_wreg_o
);

    logic [`EXEC_XLEN-1:0] dmem [`EXEC_DMEM_WORDS];

    // Address stage
    logic                    s1_load_we;
    logic                    s1_store;
    exec_pkg::mem_op_e       s1_op;
    logic [`EXEC_XLEN-1:0]   s1_addr;
    logic [`EXEC_XLEN-1:0]   s1_st_data;
    logic [`EXEC_REG_AW-1:0] s1_waddr;

    // Access stage
    logic [`EXEC_DMEM_AW-1:0] word_idx;
    logic [`EXEC_XLEN-1:0]    rd_word;
    logic [7:0]               rd_byte;
    logic [`EXEC_XLEN-1:0]    load_val;

    logic                    s2_we;
    logic                    s2_st_done;
    logic [`EXEC_REG_AW-1:0] s2_waddr;
    logic [`EXEC_XLEN-1:0]   s2_data;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_load_we <= 1'b0;
            s1_store   <= 1'b0;
        end else begin
            s1_load_we <= valid_i & we_i & (op_i != exec_pkg::MEM_SW);
            s1_store   <= valid_i & (op_i == exec_pkg::MEM_SW);
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op      <= op_i;
        s1_addr    <= base_i + offset_i;
        s1_st_data <= st_data_i;
        s1_waddr   <= waddr_i;
    end

    assign word_idx = s1_addr[`EXEC_DMEM_AW+1:2];
    assign rd_word  = dmem[word_idx];
    assign rd_byte  = rd_word[8*s1_addr[1:0] +: 8];

    always_comb begin
        case (s1_op)
            exec_pkg::MEM_LB:  load_val = {{(`EXEC_XLEN-8){rd_byte[7]}}, rd_byte};
            exec_pkg::MEM_LBU: load_val = {{(`EXEC_XLEN-8){1'b0}}, rd_byte};
            default:           load_val = rd_word;
        endcase
    end

    // Stores commit here, so a later load already sees them
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `EXEC_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (s1_store) begin
            dmem[word_idx] <= s1_st_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s2_we      <= 1'b0;
            s2_st_done <= 1'b0;
        end else begin
            s2_we      <= s1_load_we;
            s2_st_done <= s1_store;
        end
    end

    always_ff @(posedge clk_i) begin
        s2_waddr <= s1_waddr;
        s2_data  <= load_val;
    end

    assign we_o        = s2_we;
    assign waddr_o     = s2_waddr;
    assign data_o      = s2_we ? s2_data : '0;
    assign st_done_o   = s2_st_done;
    assign addr_wreg_o = s1_load_we ? s1_waddr : '0;

endmodule : mem_pipeline

// ==== logic/rvm_pipeline.sv ====
`include "exec_defs.svh"

module rvm_pipeline (
    input  logic                                                clk_i,
    input  logic                                                reset_i,
    input  logic                                                valid_i,
    input  exec_pkg::alu_op_e                                   op_i,
    input  logic [`EXEC_XLEN-1:0]                               src_a_i,
    input  logic [`EXEC_XLEN-1:0]                               src_b_i,
    input  logic                                                we_i,
    input  logic [`EXEC_REG_AW-1:0]                             waddr_i,
    output logic                                                we_o,
    output logic [`EXEC_REG_AW-1:0]                             waddr_o,
    output logic [`EXEC_XLEN-1:0]                               data_o,
    output logic [`EXEC_RVM_DEPTH-2:0][`EXEC_REG_AW-1:0]        busy_wreg_o
);

    localparam int STAGES = `EXEC_RVM_DEPTH;

    logic [STAGES-1:0]                   valid_q;
    logic [STAGES-1:0]                   we_q;
    logic [STAGES-1:0][`EXEC_REG_AW-1:0] waddr_q;
    exec_pkg::alu_op_e                   op_q [STAGES-1];

    logic                                sign_ops;
    logic signed [`EXEC_XLEN:0]          a_q;
    logic signed [`EXEC_XLEN:0]          b_q;
    logic signed [2*`EXEC_XLEN+1:0]      full_prod;
    logic [STAGES-3:0][2*`EXEC_XLEN-1:0] prod_q;
    logic [`EXEC_XLEN-1:0]               res_q;
    logic                                wr_out;

    // Only MULH treats its operands as signed
    assign sign_ops  = (op_i == exec_pkg::ALU_MULH);
    assign full_prod = a_q * b_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            we_q    <= '0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], valid_i};
            we_q    <= {we_q[STAGES-2:0], we_i};
        end
    end

    always_ff @(posedge clk_i) begin
        waddr_q <= {waddr_q[STAGES-2:0], waddr_i};
        op_q[0] <= op_i;
        for (int k = 1; k < STAGES - 1; k++) begin
            op_q[k] <= op_q[k-1];
        end
        a_q       <= {sign_ops & src_a_i[`EXEC_XLEN-1], src_a_i};
        b_q       <= {sign_ops & src_b_i[`EXEC_XLEN-1], src_b_i};
        prod_q[0] <= full_prod[2*`EXEC_XLEN-1:0];
        for (int k = 1; k < STAGES - 2; k++) begin
            prod_q[k] <= prod_q[k-1];
        end
        // Half select in the last stage
        res_q <= (op_q[STAGES-2] == exec_pkg::ALU_MUL) ?
                 prod_q[STAGES-3][`EXEC_XLEN-1:0] :
                 prod_q[STAGES-3][2*`EXEC_XLEN-1:`EXEC_XLEN];
    end

    always_comb begin
        for (int k = 0; k < STAGES - 1; k++) begin
            busy_wreg_o[k] = (valid_q[k] & we_q[k]) ? waddr_q[k] : '0;
        end
    end

    assign wr_out  = valid_q[STAGES-1] & we_q[STAGES-1];
    assign we_o    = wr_out;
    assign waddr_o = waddr_q[STAGES-1];
    assign data_o  = wr_out ? res_q : '0;

endmodule : rvm_pipeline

// ==== logic/pipeline_wrapper.sv ====
`include "exec_defs.svh"

module pipeline_wrapper (
    input  logic                                         clk_i,
    input  logic                                         reset_i,
    input  logic                                         issue_valid_i,
    input  exec_pkg::pipe_sel_e                          issue_pipe_i,
    input  exec_pkg::alu_op_e                            alu_op_i,
    input  exec_pkg::mem_op_e                            mem_op_i,
    input  logic [`EXEC_XLEN-1:0]                        src_a_i,
    input  logic [`EXEC_XLEN-1:0]                        src_b_i,
    input  exec_pkg::bypass_sel_e                        byp_a_i,
    input  exec_pkg::bypass_sel_e                        byp_b_i,
    input  logic [`EXEC_XLEN-1:0]                        st_data_i,
    input  logic                                         rd_we_i,
    input  logic [`EXEC_REG_AW-1:0]                      rd_addr_i,
    input  logic [`EXEC_XLEN-1:0]                        pc_i,
    input  logic [`EXEC_XLEN-1:0]                        br_offset_i,
    output logic                                         ex_we_o,
    output logic [`EXEC_REG_AW-1:0]                      ex_waddr_o,
    output logic [`EXEC_XLEN-1:0]                        ex_data_o,
    output logic                                         mem_we_o,
    output logic [`EXEC_REG_AW-1:0]                      mem_waddr_o,
    output logic [`EXEC_XLEN-1:0]                        mem_data_o,
    output logic                                         rvm_we_o,
    output logic [`EXEC_REG_AW-1:0]                      rvm_waddr_o,
    output logic [`EXEC_XLEN-1:0]                        rvm_data_o,
    output logic                                         st_done_o,
    output logic                                         branch_done_o,
    output logic                                         br_taken_o,
    output logic [`EXEC_XLEN-1:0]                        new_pc_o,
    output logic [`EXEC_RVM_DEPTH-2:0][`EXEC_REG_AW-1:0] rvm_busy_wreg_o,
    output logic [`EXEC_REG_AW-1:0]                      mem_addr_wreg_o
);

    logic                    ex_valid, mem_valid, rvm_valid;
    logic                    ex_we, mem_we, rvm_we;
    logic [`EXEC_REG_AW-1:0] ex_waddr, mem_waddr, rvm_waddr;
    logic [`EXEC_XLEN-1:0]   opnd_a, opnd_b;

    function automatic logic [`EXEC_XLEN-1:0] byp_pick(
        input exec_pkg::bypass_sel_e sel,
        input logic [`EXEC_XLEN-1:0] raw,
        input logic [`EXEC_XLEN-1:0] ex_res,
        input logic [`EXEC_XLEN-1:0] mem_res,
        input logic [`EXEC_XLEN-1:0] rvm_res
    );
        case (sel)
            exec_pkg::BYP_EX:  return ex_res;
            exec_pkg::BYP_MEM: return mem_res;
            exec_pkg::BYP_RVM: return rvm_res;
            default:           return raw;
        endcase
    endfunction

    // Dispatch with zeroed destinations when nothing is written
    always_comb begin
        ex_valid  = issue_valid_i & (issue_pipe_i == exec_pkg::PIPE_EX);
        mem_valid = issue_valid_i & (issue_pipe_i == exec_pkg::PIPE_MEM);
        rvm_valid = issue_valid_i & (issue_pipe_i == exec_pkg::PIPE_RVM);
        ex_we     = ex_valid & rd_we_i;
        mem_we    = mem_valid & rd_we_i;
        rvm_we    = rvm_valid & rd_we_i;
        ex_waddr  = ex_we ? rd_addr_i : '0;
        mem_waddr = mem_we ? rd_addr_i : '0;
        rvm_waddr = rvm_we ? rd_addr_i : '0;
    end

    // Result ports are already zero while idle
    assign opnd_a = byp_pick(byp_a_i, src_a_i, ex_data_o, mem_data_o, rvm_data_o);
    assign opnd_b = byp_pick(byp_b_i, src_b_i, ex_data_o, mem_data_o, rvm_data_o);

    ex_stage ex_stage_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (ex_valid),
        .op_i          (alu_op_i),
        .src_a_i       (opnd_a),
        .src_b_i       (opnd_b),
        .pc_i          (pc_i),
        .br_offset_i   (br_offset_i),
        .we_i          (ex_we),
        .waddr_i       (ex_waddr),
        .we_o          (ex_we_o),
        .waddr_o       (ex_waddr_o),
        .data_o        (ex_data_o),
        .branch_done_o (branch_done_o),
        .br_taken_o    (br_taken_o),
        .new_pc_o      (new_pc_o)
    );

    mem_pipeline mem_pipeline_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (mem_valid),
        .op_i        (mem_op_i),
        .base_i      (opnd_a),
        .offset_i    (opnd_b),
        .st_data_i   (st_data_i),
        .we_i        (mem_we),
        .waddr_i     (mem_waddr),
        .we_o        (mem_we_o),
        .waddr_o     (mem_waddr_o),
        .data_o      (mem_data_o),
        .st_done_o   (st_done_o),
        .addr_wreg_o (mem_addr_wreg_o)
    );

    rvm_pipeline rvm_pipeline_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (rvm_valid),
        .op_i        (alu_op_i),
        .src_a_i     (opnd_a),
        .src_b_i     (opnd_b),
        .we_i        (rvm_we),
        .waddr_i     (rvm_waddr),
        .we_o        (rvm_we_o),
        .waddr_o     (rvm_waddr_o),
        .data_o      (rvm_data_o),
        .busy_wreg_o (rvm_busy_wreg_o)
    );

endmodule : pipeline_wrapper

// ==== test/pipeline_wrapper_checker.sv ====
`include "exec_defs.svh"

module pipeline_wrapper_checker (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic                    ex_we_i,
    input logic [`EXEC_REG_AW-1:0] ex_waddr_i,
    input logic                    mem_we_i,
    input logic [`EXEC_REG_AW-1:0] mem_waddr_i,
    input logic                    rvm_we_i,
    input logic [`EXEC_REG_AW-1:0] rvm_waddr_i,
    input logic                    st_done_i,
    input logic                    branch_done_i,
    input logic                    br_taken_i
);

    logic collision;
    logic any_flag;

    assign collision = (ex_we_i && mem_we_i && ex_waddr_i == mem_waddr_i) ||
                       (ex_we_i && rvm_we_i && ex_waddr_i == rvm_waddr_i) ||
                       (mem_we_i && rvm_we_i && mem_waddr_i == rvm_waddr_i);
    assign any_flag  = ex_we_i || mem_we_i || rvm_we_i || st_done_i ||
                       branch_done_i || br_taken_i;

    no_write_collision: assert property (
        @(posedge clk_i) disable iff (reset_i) !collision
    ) else $error("Two pipelines write the same register in one cycle");

    quiet_after_reset: assert property (
        @(posedge clk_i) reset_i |=> !any_flag
    ) else $error("A write enable or done flag is high right after reset");

    // A store never returns load data
    store_without_write: assert property (
        @(posedge clk_i) disable iff (reset_i) !(st_done_i && mem_we_i)
    ) else $error("Store completion and MEM write-back are high together");

endmodule : pipeline_wrapper_checker

// ==== test/pipeline_wrapper_tb.sv ====
`include "exec_defs.svh"

module pipeline_wrapper_tb;

    localparam int NUM_ISSUES     = 2000;
    localparam int DEPTH          = `EXEC_RVM_DEPTH;
    localparam int DRAIN          = DEPTH + 3;
    localparam int TIMEOUT_CYCLES = NUM_ISSUES + 50;

    // One expected write-back or completion slot
    typedef struct packed {
        logic                    we;
        logic [`EXEC_REG_AW-1:0] waddr;
        logic [`EXEC_XLEN-1:0]   data;
        logic                    done;
        logic                    taken;
        logic [`EXEC_XLEN-1:0]   pc;
    } wb_t;

    logic                  clk_i, reset_i, issue_valid_i, rd_we_i;
    exec_pkg::pipe_sel_e   issue_pipe_i;
    exec_pkg::alu_op_e     alu_op_i;
    exec_pkg::mem_op_e     mem_op_i;
    exec_pkg::bypass_sel_e byp_a_i, byp_b_i;
    logic [`EXEC_XLEN-1:0] src_a_i, src_b_i, st_data_i, pc_i, br_offset_i;
    logic [`EXEC_REG_AW-1:0] rd_addr_i;

    logic                    ex_we_o, mem_we_o, rvm_we_o;
    logic [`EXEC_REG_AW-1:0] ex_waddr_o, mem_waddr_o, rvm_waddr_o, mem_addr_wreg_o;
    logic [`EXEC_XLEN-1:0]   ex_data_o, mem_data_o, rvm_data_o, new_pc_o;
    logic                    st_done_o, branch_done_o, br_taken_o;
    logic [DEPTH-2:0][`EXEC_REG_AW-1:0] rvm_busy_wreg_o;

    logic [31:0]           lfsr;
    int                    cycle_count;
    int                    n_alu, n_branches, n_loads, n_stores, n_muls;
    logic [`EXEC_XLEN-1:0] mem_img [`EXEC_DMEM_WORDS];
    // Front entry is what the ports show this cycle
    wb_t                   ex_q[$];
    wb_t                   mem_q[$];
    wb_t                   rvm_q[$];

    pipeline_wrapper pipeline_wrapper_i (.*);

    bind pipeline_wrapper pipeline_wrapper_checker pipeline_wrapper_checker_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ex_we_i       (ex_we_o),
        .ex_waddr_i    (ex_waddr_o),
        .mem_we_i      (mem_we_o),
        .mem_waddr_i   (mem_waddr_o),
        .rvm_we_i      (rvm_we_o),
        .rvm_waddr_i   (rvm_waddr_o),
        .st_done_i     (st_done_o),
        .branch_done_i (branch_done_o),
        .br_taken_i    (br_taken_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the test did not reach its end", cycle_count);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] alu_result(exec_pkg::alu_op_e op, logic [31:0] a,
                                               logic [31:0] b);
        case (op)
            exec_pkg::ALU_ADD: return a + b;
            exec_pkg::ALU_SUB: return a - b;
            exec_pkg::ALU_AND: return a & b;
            exec_pkg::ALU_OR:  return a | b;
            exec_pkg::ALU_XOR: return a ^ b;
            exec_pkg::ALU_SLL: return a << b[4:0];
            exec_pkg::ALU_SRL: return a >> b[4:0];
            exec_pkg::ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
            default:           return '0;
        endcase
    endfunction

    function automatic logic branch_taken(exec_pkg::alu_op_e op, logic [31:0] a,
                                          logic [31:0] b);
        case (op)
            exec_pkg::ALU_BEQ: return a == b;
            exec_pkg::ALU_BNE: return a != b;
            default:           return $signed(a) < $signed(b);
        endcase
    endfunction

    function automatic logic [31:0] mul_result(exec_pkg::alu_op_e op, logic [31:0] a,
                                               logic [31:0] b);
        logic [63:0] prod_u;
        logic [63:0] prod_s;
        prod_u = {32'b0, a} * {32'b0, b};
        // Low 64 bits of the sign-extended product are the signed product
        prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        case (op)
            exec_pkg::ALU_MUL:  return prod_u[31:0];
            exec_pkg::ALU_MULH: return prod_s[63:32];
            default:            return prod_u[63:32];
        endcase
    endfunction

    function automatic logic [31:0] load_value(exec_pkg::mem_op_e op, logic [31:0] word,
                                               logic [1:0] lane);
        logic [7:0] lb;
        lb = 8'(word >> (8 * lane));
        case (op)
            exec_pkg::MEM_LB:  return {{24{lb[7]}}, lb};
            exec_pkg::MEM_LBU: return {24'b0, lb};
            default:           return word;
        endcase
    endfunction

    // Bypass from the expected result ports of this cycle
    function automatic logic [31:0] pick_operand(exec_pkg::bypass_sel_e sel, logic [31:0] raw);
        case (sel)
            exec_pkg::BYP_EX:  return ex_q[0].data;
            exec_pkg::BYP_MEM: return mem_q[0].data;
            exec_pkg::BYP_RVM: return rvm_q[0].data;
            default:           return raw;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0h, actual %0h", what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_outputs(input int cyc);
        string tag;
        wb_t   busy;
        tag = $sformatf("cycle %0d", cyc);
        check_value({tag, " ex_we"}, 64'(ex_q[0].we), 64'(ex_we_o));
        check_value({tag, " ex_data"}, 64'(ex_q[0].data), 64'(ex_data_o));
        if (ex_q[0].we)
            check_value({tag, " ex_waddr"}, 64'(ex_q[0].waddr), 64'(ex_waddr_o));
        check_value({tag, " branch_done"}, 64'(ex_q[0].done), 64'(branch_done_o));
        check_value({tag, " br_taken"}, 64'(ex_q[0].taken), 64'(br_taken_o));
        if (ex_q[0].done)
            check_value({tag, " new_pc"}, 64'(ex_q[0].pc), 64'(new_pc_o));
        check_value({tag, " mem_we"}, 64'(mem_q[0].we), 64'(mem_we_o));
        check_value({tag, " mem_data"}, 64'(mem_q[0].data), 64'(mem_data_o));
        if (mem_q[0].we)
            check_value({tag, " mem_waddr"}, 64'(mem_q[0].waddr), 64'(mem_waddr_o));
        check_value({tag, " st_done"}, 64'(mem_q[0].done), 64'(st_done_o));
        check_value({tag, " mem_addr_wreg"}, 64'(mem_q[1].we ? mem_q[1].waddr : 5'd0),
                    64'(mem_addr_wreg_o));
        check_value({tag, " rvm_we"}, 64'(rvm_q[0].we), 64'(rvm_we_o));
        check_value({tag, " rvm_data"}, 64'(rvm_q[0].data), 64'(rvm_data_o));
        if (rvm_q[0].we)
            check_value({tag, " rvm_waddr"}, 64'(rvm_q[0].waddr), 64'(rvm_waddr_o));
        // Stage k holds the operation issued k+1 cycles ago
        for (int k = 0; k < DEPTH - 1; k++) begin
            busy = rvm_q[DEPTH-1-k];
            check_value({tag, $sformatf(" rvm_busy_wreg[%0d]", k)},
                        64'(busy.we ? busy.waddr : 5'd0), 64'(rvm_busy_wreg_o[k]));
        end
    endtask

    task automatic issue_cycle(input bit active);
        wb_t                 ex_n, mem_n, rvm_n;
        exec_pkg::pipe_sel_e pipe;
        logic [31:0]         r, q, a, b, addr;
        logic                valid;
        ex_n  = '0;
        mem_n = '0;
        rvm_n = '0;
        r     = rand_bits(3);
        valid = active && (r[2:0] != 3'd0);
        r     = rand_bits(2);
        pipe  = exec_pkg::pipe_sel_e'(r[1:0]);
        r     = rand_bits(4);
        q     = rand_bits(4);
        mem_op_i = exec_pkg::mem_op_e'(r[1:0]);
        // Destinations split by pipeline so no two collide
        case (pipe)
            exec_pkg::PIPE_EX: begin
                alu_op_i  = exec_pkg::alu_op_e'(4'(r % 11));
                rd_addr_i = 5'(1 + q % 10);
            end
            exec_pkg::PIPE_MEM: begin
                alu_op_i  = exec_pkg::ALU_ADD;
                rd_addr_i = 5'(11 + q % 10);
            end
            default: begin
                alu_op_i  = exec_pkg::alu_op_e'(4'(11 + r % 3));
                rd_addr_i = 5'(21 + q % 11);
            end
        endcase
        src_a_i = (pipe == exec_pkg::PIPE_MEM) ? rand_bits(7) : rand_bits(32);
        src_b_i = (pipe == exec_pkg::PIPE_MEM) ? rand_bits(7) : rand_bits(32);
        r = rand_bits(2);
        if (r[1:0] == 2'd0)
            src_b_i = src_a_i;
        r = rand_bits(3);
        byp_a_i = r[2] ? exec_pkg::bypass_sel_e'(r[1:0]) : exec_pkg::BYP_NONE;
        r = rand_bits(3);
        byp_b_i = r[2] ? exec_pkg::bypass_sel_e'(r[1:0]) : exec_pkg::BYP_NONE;
        r = rand_bits(3);
        rd_we_i       = (r[2:0] != 3'd0);
        st_data_i     = rand_bits(32);
        r             = rand_bits(30);
        pc_i          = {r[29:0], 2'b00};
        r             = rand_bits(12);
        br_offset_i   = {{19{r[11]}}, r[11:0], 1'b0};
        issue_valid_i = valid;
        issue_pipe_i  = pipe;

        a = pick_operand(byp_a_i, src_a_i);
        b = pick_operand(byp_b_i, src_b_i);
        if (valid && pipe == exec_pkg::PIPE_EX) begin
            if (alu_op_i == exec_pkg::ALU_BEQ || alu_op_i == exec_pkg::ALU_BNE ||
                alu_op_i == exec_pkg::ALU_BLT) begin
                ex_n.done  = 1'b1;
                ex_n.taken = branch_taken(alu_op_i, a, b);
                ex_n.pc    = ex_n.taken ? pc_i + br_offset_i : pc_i + 32'd4;
                n_branches++;
            end else begin
                ex_n.we    = rd_we_i;
                ex_n.waddr = rd_addr_i;
                ex_n.data  = rd_we_i ? alu_result(alu_op_i, a, b) : '0;
                n_alu++;
            end
        end
        // Memory ops run in program order, so the image is updated at issue
        if (valid && pipe == exec_pkg::PIPE_MEM) begin
            addr = a + b;
            if (mem_op_i == exec_pkg::MEM_SW) begin
                mem_img[addr[7:2]] = st_data_i;
                mem_n.done = 1'b1;
                n_stores++;
            end else begin
                mem_n.we    = rd_we_i;
                mem_n.waddr = rd_addr_i;
                mem_n.data  = rd_we_i ? load_value(mem_op_i, mem_img[addr[7:2]], addr[1:0]) : '0;
                n_loads++;
            end
        end
        if (valid && pipe == exec_pkg::PIPE_RVM) begin
            rvm_n.we    = rd_we_i;
            rvm_n.waddr = rd_addr_i;
            rvm_n.data  = rd_we_i ? mul_result(alu_op_i, a, b) : '0;
            n_muls++;
        end
        ex_q.push_back(ex_n);
        void'(ex_q.pop_front());
        mem_q.push_back(mem_n);
        void'(mem_q.pop_front());
        rvm_q.push_back(rvm_n);
        void'(rvm_q.pop_front());
    endtask

    initial begin
        lfsr          = 32'h764e;
        reset_i       = 1'b1;
        issue_valid_i = 1'b0;
        issue_pipe_i  = exec_pkg::PIPE_NONE;
        alu_op_i      = exec_pkg::ALU_ADD;
        mem_op_i      = exec_pkg::MEM_LW;
        byp_a_i       = exec_pkg::BYP_NONE;
        byp_b_i       = exec_pkg::BYP_NONE;
        src_a_i       = '0;
        src_b_i       = '0;
        st_data_i     = '0;
        rd_we_i       = 1'b0;
        rd_addr_i     = '0;
        pc_i          = '0;
        br_offset_i   = '0;
        for (int i = 0; i < `EXEC_DMEM_WORDS; i++)
            mem_img[i] = '0;
        ex_q.push_back('0);
        repeat (2) mem_q.push_back('0);
        repeat (DEPTH) rvm_q.push_back('0);

        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        for (int cyc = 0; cyc < NUM_ISSUES + DRAIN; cyc++) begin
            check_outputs(cyc);
            issue_cycle(cyc < NUM_ISSUES);
            @(posedge clk_i);
            #1;
        end

        if (n_alu == 0 || n_branches == 0 || n_loads == 0 || n_stores == 0 || n_muls == 0) begin
            $display("Random stimulus never issued one class of operation");
            $display("Simulation FAILED");
            $fatal(1, "incomplete stimulus");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule : pipeline_wrapper_tb

// ==== exec_backend.f ====
+incdir+logic
logic/exec_pkg.sv
logic/ex_stage.sv
logic/mem_pipeline.sv
logic/rvm_pipeline.sv
logic/pipeline_wrapper.sv
test/pipeline_wrapper_checker.sv
test/pipeline_wrapper_tb.sv

// ==== Makefile ====
SIM       ?= verilator
TOP       ?= pipeline_wrapper_tb
FILELIST  ?= exec_backend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
